//--- rtl/pet_bus_pkg.sv
`default_nettype none

package pet_bus_pkg;

    typedef logic [16:0] addr_t;                            // 17 bit system address
    typedef logic [7:0]  data_t;                            // System data byte

    // One access on the shared bus
    typedef struct packed {
        logic  rw_n;                                        // 1 = read, 0 = write
        addr_t addr;                                        // Target address
        data_t wdata;                                       // Write data, ignored on reads
    } bus_req_t;

    // PET memory map
    localparam addr_t ADDR_VRAM_LO  = 17'h0_8000;           // Video RAM window start
    localparam addr_t ADDR_VRAM_HI  = 17'h0_8FFF;           // Video RAM window end
    localparam addr_t ADDR_ROM_LO   = 17'h0_9000;           // Read-only from here up
    localparam addr_t ADDR_IO_LO    = 17'h0_E800;           // I/O page E800 to EFFF
    localparam addr_t ADDR_PIA1     = 17'h0_E810;           // Keyboard PIA
    localparam addr_t ADDR_PIA2     = 17'h0_E820;           // IEEE-488 PIA
    localparam addr_t ADDR_VIA      = 17'h0_E840;           // User port VIA
    localparam addr_t ADDR_KBD_ROWS = 17'h0_E800;           // Pi fills keyboard rows here
    localparam addr_t ADDR_GFX      = 17'h0_E80E;           // Pi read of the gfx input
    localparam addr_t ADDR_CTL      = 17'h0_E80F;           // Pi control register

    localparam int KBD_ROW_COUNT = 10;                      // Rows in the PET key matrix

    // Sixteen 16 MHz phases make one 1 MHz CPU cycle
    localparam int PHASE_W = 4;
    localparam logic [PHASE_W-1:0] PHASE_PI_ON  = PHASE_W'(2);  // First Pi slot phase
    localparam logic [PHASE_W-1:0] PHASE_PI_OFF = PHASE_W'(3);  // Last Pi slot phase
    localparam logic [PHASE_W-1:0] PHASE_CPU_ON = PHASE_W'(4);  // CPU owns bus from here
    localparam logic [PHASE_W-1:0] PHASE_CLK_HI = PHASE_W'(8);  // CPU clock rises here

endpackage

`default_nettype wire

//--- rtl/pet_spi_pkg.sv
`default_nettype none

package pet_spi_pkg;

    localparam int FRAME_BYTES = 4;                         // cmd, addr_hi, addr_lo, data
    localparam int FRAME_BITS  = FRAME_BYTES * 8;
    localparam int BIT_CNT_W   = $clog2(FRAME_BITS);        // Bit counter over one frame

    // First byte of a frame
    typedef struct packed {
        logic       rw_n;                                   // 1 = Pi read, 0 = Pi write
        logic       a16;                                    // Address bit 16
        logic [5:0] unused;                                 // Reserved, sent as zero
    } pi_cmd_t;

    // Whole frame, first byte on the wire in the top bits
    typedef struct packed {
        pi_cmd_t    cmd;
        logic [7:0] addr_hi;                                // Address bits 15:8
        logic [7:0] addr_lo;                                // Address bits 7:0
        logic [7:0] data;                                   // Write data, don't care on reads
    } spi_frame_t;

endpackage

`default_nettype wire

//--- rtl/spi_bridge.sv
`default_nettype none

module spi_bridge (
    input  logic                  clk_16_i,                 // 16 MHz system clock
    input  logic                  rst_i,                    // Synchronous reset
    input  logic                  spi_sclk_i,               // SPI clock from Pi, mode 0
    input  logic                  spi_cs_ni,                // SPI chip select
    input  logic                  spi_rx_i,                 // MOSI
    output logic                  spi_tx_o,                 // MISO
    input  pet_bus_pkg::data_t    rd_data_i,                // Byte from the last Pi read
    input  logic                  spi_done_i,               // Pi slot just finished
    output pet_bus_pkg::bus_req_t spi_req_o,                // Pending bus access
    output logic                  spi_valid_o,              // Command pending
    output logic                  spi_ready_no              // 0 = command done
);
    logic [2:0] sclk_sync_q;                                // Two sync stages plus edge stage
    logic [2:0] cs_sync_q;
    logic [1:0] rx_sync_q;                                  // Lines up with sclk_sync_q[1]
    logic [pet_spi_pkg::BIT_CNT_W-1:0] bit_cnt_q;           // Bits received this frame
    pet_spi_pkg::spi_frame_t frame_q;                       // Receive shift register
    pet_spi_pkg::spi_frame_t frame_next;                    // Frame after the current bit
    pet_bus_pkg::data_t tx_shift_q;                         // Transmit shift register
    logic ready_q;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_low;
    logic cs_fall;
    logic accept;                                           // Full frame taken as a command

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            sclk_sync_q <= '0;
            cs_sync_q   <= '1;                              // Deselected
            rx_sync_q   <= '0;
        end else begin
            sclk_sync_q <= {sclk_sync_q[1:0], spi_sclk_i};
            cs_sync_q   <= {cs_sync_q[1:0], spi_cs_ni};
            rx_sync_q   <= {rx_sync_q[0], spi_rx_i};
        end
    end

    assign sclk_rise  = sclk_sync_q[1] && !sclk_sync_q[2];  // Sample edge in mode 0
    assign sclk_fall  = !sclk_sync_q[1] && sclk_sync_q[2];  // Shift-out edge
    assign cs_low     = !cs_sync_q[1];
    assign cs_fall    = !cs_sync_q[1] && cs_sync_q[2];      // Frame start
    assign frame_next = {frame_q[pet_spi_pkg::FRAME_BITS-2:0], rx_sync_q[1]}; // MSB first
    assign accept     = cs_low && sclk_rise && !spi_valid_o
                     && bit_cnt_q == pet_spi_pkg::BIT_CNT_W'(pet_spi_pkg::FRAME_BITS - 1);

    always_ff @(posedge clk_16_i) begin
        if (rst_i || !cs_low) begin
            bit_cnt_q <= '0;                                // Realign on every chip select
        end else if (sclk_rise) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;                  // Wraps after the last bit
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (cs_low && sclk_rise) begin
            frame_q <= frame_next;
        end
        if (cs_fall) begin
            tx_shift_q <= rd_data_i;                        // First bit out before first edge
        end else if (cs_low && sclk_fall) begin
            tx_shift_q <= {tx_shift_q[6:0], 1'b0};          // Zeros after the read byte
        end
    end

    assign spi_tx_o = tx_shift_q[7];

    always_ff @(posedge clk_16_i) begin
        if (accept) begin                                   // Frame sent while busy is dropped
            spi_req_o.rw_n  <= frame_next.cmd.rw_n;
            spi_req_o.addr  <= {frame_next.cmd.a16, frame_next.addr_hi, frame_next.addr_lo};
            spi_req_o.wdata <= frame_next.data;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            spi_valid_o <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            if (cs_fall) begin
                ready_q <= 1'b0;                            // New frame under way
            end
            if (spi_done_i) begin
                spi_valid_o <= 1'b0;
                ready_q     <= 1'b1;                        // Read data now held for the Pi
            end else if (accept) begin
                spi_valid_o <= 1'b1;
            end
        end
    end

    assign spi_ready_no = !ready_q;

endmodule

`default_nettype wire

//--- rtl/bus_timing.sv
`default_nettype none

module bus_timing (
    input  logic clk_16_i,                                  // 16 MHz system clock
    input  logic rst_i,                                     // Synchronous reset
    input  logic spi_valid_i,                               // Pi command pending
    input  logic cpu_ready_i,                               // 1 = CPU may run
    output logic clk_cpu_o,                                 // 1 MHz CPU clock
    output logic spi_en_o,                                  // Pi owns the bus
    output logic spi_done_o,                                // Last cycle of the Pi slot
    output logic cpu_en_o                                   // CPU owns the bus
);
    logic [pet_bus_pkg::PHASE_W-1:0] phase_q;               // One lap per CPU cycle
    logic slot_q;                                           // Pi granted in this cycle

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            phase_q <= '0;
            slot_q  <= 1'b0;
        end else begin
            phase_q <= phase_q + 1'b1;                      // Free running, wraps at 15
            if (phase_q == '0) begin
                slot_q <= spi_valid_i;                      // Grant is decided at phase 0 only
            end else if (phase_q == pet_bus_pkg::PHASE_PI_OFF) begin
                slot_q <= 1'b0;
            end
        end
    end

    assign spi_en_o   = slot_q && (phase_q == pet_bus_pkg::PHASE_PI_ON
                                || phase_q == pet_bus_pkg::PHASE_PI_OFF);
    assign spi_done_o = slot_q && phase_q == pet_bus_pkg::PHASE_PI_OFF;  // Strobe at slot end
    assign clk_cpu_o  = phase_q >= pet_bus_pkg::PHASE_CLK_HI;            // High in phases 8-15
    assign cpu_en_o   = cpu_ready_i && phase_q >= pet_bus_pkg::PHASE_CPU_ON;  // Halted CPU off bus

endmodule

`default_nettype wire

//--- rtl/address_decoding.sv
`default_nettype none

module address_decoding (
    input  pet_bus_pkg::addr_t addr_i,                      // Current bus address
    output logic               ram_en_o,                    // RAM below E800
    output logic               io_en_o,                     // I/O page E800-EFFF
    output logic               pia1_en_o,                   // E810-E81F
    output logic               pia2_en_o,                   // E820-E82F
    output logic               via_en_o,                    // E840-E84F
    output logic               is_readonly_o,               // 9000 and up
    output logic               is_mirrored_o                // 40 column video RAM window
);
    // I/O page is one 2 KB block, each chip a 16 byte block
    assign io_en_o   = addr_i[16:11] == pet_bus_pkg::ADDR_IO_LO[16:11];
    assign pia1_en_o = addr_i[16:4] == pet_bus_pkg::ADDR_PIA1[16:4];
    assign pia2_en_o = addr_i[16:4] == pet_bus_pkg::ADDR_PIA2[16:4];
    assign via_en_o  = addr_i[16:4] == pet_bus_pkg::ADDR_VIA[16:4];

    assign ram_en_o      = addr_i < pet_bus_pkg::ADDR_IO_LO;
    assign is_readonly_o = addr_i >= pet_bus_pkg::ADDR_ROM_LO;  // ROM images live in RAM
    assign is_mirrored_o = addr_i >= pet_bus_pkg::ADDR_VRAM_LO
                        && addr_i <= pet_bus_pkg::ADDR_VRAM_HI;  // 1 KB seen four times

endmodule

`default_nettype wire

//--- rtl/keyboard.sv
`default_nettype none

module keyboard (
    input  logic                  clk_16_i,                 // 16 MHz system clock
    input  logic                  rst_i,                    // Synchronous reset
    input  pet_bus_pkg::bus_req_t spi_req_i,                // Pi access in the slot
    input  logic                  spi_wr_en_i,              // Pi write slot
    input  logic                  pia1_en_i,                // Address in PIA1 block
    input  logic                  cpu_rd_en_i,              // CPU read cycle
    input  logic                  cpu_wr_en_i,              // CPU write cycle
    input  logic [1:0]            bus_addr_i,               // PIA1 register select
    input  pet_bus_pkg::data_t    bus_data_i,               // CPU write data
    output pet_bus_pkg::data_t    kbd_data_o,               // Row byte for port B
    output logic                  kbd_en_o                  // 1 = intercept this read
);
    pet_bus_pkg::data_t rows_q [pet_bus_pkg::KBD_ROW_COUNT];  // 0 bit = key down
    logic [3:0]         row_sel_q;                          // Row picked through port A
    pet_bus_pkg::addr_t row_off;                            // Pi address within row block
    logic               row_wr;                             // Pi write hits a row

    assign row_off = spi_req_i.addr - pet_bus_pkg::ADDR_KBD_ROWS;
    assign row_wr  = spi_wr_en_i && spi_req_i.addr >= pet_bus_pkg::ADDR_KBD_ROWS
                  && row_off < pet_bus_pkg::addr_t'(pet_bus_pkg::KBD_ROW_COUNT);

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            for (int i = 0; i < pet_bus_pkg::KBD_ROW_COUNT; i++) begin
                rows_q[i] <= 8'hFF;                         // No key pressed
            end
        end else if (row_wr) begin
            rows_q[row_off[3:0]] <= spi_req_i.wdata;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            row_sel_q <= '0;
        end else if (cpu_wr_en_i && pia1_en_i && bus_addr_i == 2'd0) begin
            row_sel_q <= bus_data_i[3:0];                   // E810, low nibble picks the row
        end
    end

    // Port B at E812 reads the selected row instead of the PIA
    assign kbd_en_o   = cpu_rd_en_i && pia1_en_i && bus_addr_i == 2'd2;
    assign kbd_data_o = (row_sel_q < 4'(pet_bus_pkg::KBD_ROW_COUNT))
                      ? rows_q[row_sel_q]
                      : 8'hFF;                              // Rows 10-15 have no keys

endmodule

`default_nettype wire

//--- rtl/pi_ctl.sv
`default_nettype none

module pi_ctl (
    input  logic                  clk_16_i,                 // 16 MHz system clock
    input  logic                  rst_i,                    // Synchronous reset
    input  logic                  spi_wr_en_i,              // Pi write slot
    input  pet_bus_pkg::bus_req_t spi_req_i,                // Pi access in the slot
    output logic                  cpu_res_no,               // 0 = CPU held in reset
    output logic                  cpu_ready_o               // 1 = CPU runs
);
    always_ff @(posedge clk_16_i) begin
        if (rst_i) begin
            cpu_res_no  <= 1'b0;                            // CPU waits until the Pi is up
            cpu_ready_o <= 1'b0;
        end else if (spi_wr_en_i && spi_req_i.addr == pet_bus_pkg::ADDR_CTL) begin
            cpu_res_no  <= spi_req_i.wdata[0];              // 1 releases reset
            cpu_ready_o <= spi_req_i.wdata[1];
        end
    end

endmodule

`default_nettype wire

//--- rtl/main.sv
`default_nettype none

module main (
    input  logic               clk_16_i,                    // 16 MHz main clock
    input  logic               rst_i,                       // Synchronous reset
    input  pet_bus_pkg::addr_t bus_addr_i,                  // Address from the CPU
    input  logic               bus_rw_n_i,                  // 1 = CPU read, 0 = CPU write
    input  pet_bus_pkg::data_t bus_data_i,                  // Data seen on the bus
    input  logic               spi_sclk_i,
    input  logic               spi_cs_ni,
    input  logic               spi_rx_i,
    input  logic               gfx_i,                       // Graphics jumper
    output pet_bus_pkg::addr_t bus_addr_o,
    output logic               bus_addr_oe_o,               // 1 = Pi drives address
    output logic               bus_rw_n_o,
    output logic               bus_rw_n_oe_o,               // 1 = Pi drives rw_n
    output pet_bus_pkg::data_t bus_data_o,
    output logic               bus_data_oe_o,               // 1 = we drive data
    output logic [11:10]       ram_addr_o,                  // RAM A11/A10, mirrors VRAM
    output logic               spi_tx_o,
    output logic               spi_ready_no,                // 0 = Pi command done
    output logic               clk_cpu_o,                   // 1 MHz CPU clock
    output logic               ram_oe_no,
    output logic               ram_we_no,
    output logic               ram_ce_no,
    output logic               cpu_res_no,
    output logic               cpu_ready_o,
    output logic               cpu_en_o,                    // CPU bus enable
    output logic               pia1_cs2_no,
    output logic               pia2_cs2_no,
    output logic               via_cs2_no,
    output logic               io_oe_no                     // I/O data buffer enable
);
    pet_bus_pkg::bus_req_t spi_req;
    pet_bus_pkg::addr_t    dec_addr;                        // Address seen by the decoder
    pet_bus_pkg::data_t    rd_data_q;                       // Last Pi read result
    pet_bus_pkg::data_t    kbd_data;
    logic spi_valid, spi_en, spi_done;
    logic spi_rd_en, spi_wr_en, cpu_rd_en, cpu_wr_en;
    logic ram_en, io_en, pia1_en, pia2_en, via_en, is_readonly, is_mirrored;
    logic kbd_en;

    spi_bridge u_spi_bridge (
        .clk_16_i, .rst_i, .spi_sclk_i, .spi_cs_ni, .spi_rx_i, .spi_tx_o,
        .rd_data_i(rd_data_q), .spi_done_i(spi_done), .spi_req_o(spi_req),
        .spi_valid_o(spi_valid), .spi_ready_no
    );

    bus_timing u_bus_timing (
        .clk_16_i, .rst_i, .spi_valid_i(spi_valid), .cpu_ready_i(cpu_ready_o),
        .clk_cpu_o, .spi_en_o(spi_en), .spi_done_o(spi_done), .cpu_en_o
    );

    assign spi_rd_en = spi_en && spi_req.rw_n;
    assign spi_wr_en = spi_en && !spi_req.rw_n;
    assign cpu_rd_en = cpu_en_o && bus_rw_n_i;
    assign cpu_wr_en = cpu_en_o && !bus_rw_n_i;
    assign dec_addr  = spi_en ? spi_req.addr : bus_addr_i;  // Pi address during its slot

    address_decoding u_address_decoding (
        .addr_i(dec_addr), .ram_en_o(ram_en), .io_en_o(io_en), .pia1_en_o(pia1_en),
        .pia2_en_o(pia2_en), .via_en_o(via_en), .is_readonly_o(is_readonly),
        .is_mirrored_o(is_mirrored)
    );

    keyboard u_keyboard (
        .clk_16_i, .rst_i, .spi_req_i(spi_req), .spi_wr_en_i(spi_wr_en), .pia1_en_i(pia1_en),
        .cpu_rd_en_i(cpu_rd_en), .cpu_wr_en_i(cpu_wr_en), .bus_addr_i(bus_addr_i[1:0]),
        .bus_data_i, .kbd_data_o(kbd_data), .kbd_en_o(kbd_en)
    );

    pi_ctl u_pi_ctl (
        .clk_16_i, .rst_i, .spi_wr_en_i(spi_wr_en), .spi_req_i(spi_req), .cpu_res_no,
        .cpu_ready_o
    );

    // Chip selects only in the CPU part of the cycle, PIA1 and I/O buffer yield to keyboard
    assign pia1_cs2_no = !(pia1_en && !kbd_en && cpu_en_o);
    assign pia2_cs2_no = !(pia2_en && cpu_en_o);
    assign via_cs2_no  = !(via_en && cpu_en_o);
    assign io_oe_no    = !(io_en && !kbd_en && cpu_en_o);

    assign ram_ce_no = !(ram_en && (spi_en || cpu_en_o));
    assign ram_oe_no = !(spi_rd_en || cpu_rd_en);
    assign ram_we_no = !(spi_wr_en || (cpu_wr_en && clk_cpu_o && !is_readonly));  // ROM kept

    always_ff @(posedge clk_16_i) begin
        if (spi_rd_en && spi_done) begin                    // Bus data settled by end of phase 3
            rd_data_q <= (spi_req.addr == pet_bus_pkg::ADDR_GFX) ? {7'b0, gfx_i} : bus_data_i;
        end
    end

    assign bus_addr_o    = spi_req.addr;
    assign bus_addr_oe_o = spi_en;
    assign bus_rw_n_o    = spi_req.rw_n;
    assign bus_rw_n_oe_o = spi_en;                          // CPU drives rw_n otherwise
    assign bus_data_o    = spi_wr_en ? spi_req.wdata : kbd_data;
    assign bus_data_oe_o = spi_wr_en || kbd_en;             // Pi write data or key row

    assign ram_addr_o = spi_en      ? spi_req.addr[11:10]   // Pi sees the full RAM
                      : is_mirrored ? 2'b00                 // 1 KB VRAM repeats through 8FFF
                      : bus_addr_i[11:10];

endmodule

`default_nettype wire

//--- tb/main_assert.sv
`default_nettype none

module main_assert (
    input logic               clk_16_i,
    input logic               rst_i,
    input logic               spi_en_i,                     // Pi slot in the cycle
    input logic               spi_valid_i,                  // Pi command pending
    input logic               cpu_en_i,                     // CPU part of the cycle
    input logic               clk_cpu_i,
    input pet_bus_pkg::addr_t bus_addr_i,                   // Address from the CPU
    input logic               ram_we_ni,
    input logic               bus_addr_oe_i                 // Pi drives the address bus
);
    int fail_cnt = 0;                                       // Count of assertion failures

    // Only one owner of the shared bus at a time
    a_one_owner: assert property (@(posedge clk_16_i) disable iff (rst_i)
        !(spi_en_i && cpu_en_i))
        else begin
            $error("Pi slot and CPU bus enable active together");
            fail_cnt++;
        end

    // ROM images from 9000 up never see a CPU write strobe
    a_rom_kept: assert property (@(posedge clk_16_i) disable iff (rst_i)
        (cpu_en_i && bus_addr_i >= pet_bus_pkg::ADDR_ROM_LO) |-> ram_we_ni)
        else begin
            $error("RAM write strobe on a read-only CPU address");
            fail_cnt++;
        end

    // Pi address only for a pending command, early in the CPU cycle
    a_addr_drive: assert property (@(posedge clk_16_i) disable iff (rst_i)
        bus_addr_oe_i |-> (spi_valid_i && !cpu_en_i && !clk_cpu_i))
        else begin
            $error("Address bus driven outside the Pi slot");
            fail_cnt++;
        end

endmodule

bind main main_assert u_main_assert (
    .clk_16_i, .rst_i, .spi_en_i(spi_en), .spi_valid_i(spi_valid), .cpu_en_i(cpu_en_o),
    .clk_cpu_i(clk_cpu_o), .bus_addr_i, .ram_we_ni(ram_we_no), .bus_addr_oe_i(bus_addr_oe_o)
);

`default_nettype wire

//--- tb/main_tb.sv
`default_nettype none

module main_tb;
    localparam int N_VECS   = 9;
    localparam int N_SPI    = 10;                           // Frames sent over the whole run
    localparam int WATCHDOG = (N_VECS + N_SPI) * 2000;

    // One CPU access and the strobes it should give
    typedef struct packed {
        pet_bus_pkg::addr_t addr;
        logic               rw_n;
        logic [3:0]         cs_n;                           // PIA1, PIA2, VIA, io_oe
        logic               ce_n;
        logic               oe_n;                           // Low on every CPU read
        logic               we_n;                           // Seen while CPU clock is high
        logic [1:0]         ram_a;                          // Expected A11/A10
    } vec_t;

    vec_t vecs [N_VECS] = '{
        {17'h0_0400, 1'b0, 4'b1111, 1'b0, 1'b1, 1'b0, 2'b01},   // Plain RAM write
        {17'h0_8C00, 1'b0, 4'b1111, 1'b0, 1'b1, 1'b0, 2'b00},   // VRAM mirror folds A11/A10
        {17'h0_9800, 1'b0, 4'b1111, 1'b0, 1'b1, 1'b1, 2'b10},   // ROM area, write blocked
        {17'h0_E810, 1'b1, 4'b0110, 1'b1, 1'b0, 1'b1, 2'b10},   // PIA1 port A
        {17'h0_E822, 1'b1, 4'b1010, 1'b1, 1'b0, 1'b1, 2'b10},   // PIA2
        {17'h0_E84F, 1'b0, 4'b1100, 1'b1, 1'b1, 1'b1, 2'b10},   // VIA write, no RAM strobe
        {17'h0_EC00, 1'b1, 4'b1110, 1'b1, 1'b0, 1'b1, 2'b11},   // I/O page, no chip
        {17'h0_1234, 1'b1, 4'b1111, 1'b0, 1'b0, 1'b1, 2'b00},
        {17'h0_F000, 1'b1, 4'b1111, 1'b1, 1'b0, 1'b1, 2'b00}    // Above the I/O page
    };

    logic clk_16_i, rst_i, bus_rw_n_i, spi_sclk_i, spi_cs_ni, spi_rx_i, gfx_i;
    pet_bus_pkg::addr_t bus_addr_i, bus_addr_o;
    pet_bus_pkg::data_t bus_data_i, bus_data_o;
    logic bus_addr_oe_o, bus_rw_n_o, bus_rw_n_oe_o, bus_data_oe_o;
    logic [11:10] ram_addr_o;
    logic spi_tx_o, spi_ready_no, clk_cpu_o, ram_oe_no, ram_we_no, ram_ce_no;
    logic cpu_res_no, cpu_ready_o, cpu_en_o, pia1_cs2_no, pia2_cs2_no, via_cs2_no, io_oe_no;

    pet_bus_pkg::data_t mem [8192];                         // 8 KB RAM model
    pet_bus_pkg::addr_t ram_src;                            // Whoever drives the address
    logic [12:0]        ram_idx;
    pet_bus_pkg::data_t cpu_wdata;                          // CPU side of the data bus
    pet_bus_pkg::data_t rx, wdata;
    pet_bus_pkg::data_t rows [2];
    pet_bus_pkg::addr_t pi_addr;
    pet_bus_pkg::addr_t exp_pi_addr;                        // Frame now in flight
    logic               exp_pi_rw_n;
    pet_bus_pkg::data_t exp_pi_wdata;
    int unsigned        slot_cycles = 0;                    // Cycles with the Pi on the bus

    main i_main (.*);

    assign ram_src    = bus_addr_oe_o ? bus_addr_o : bus_addr_i;
    assign ram_idx    = {ram_src[12], ram_addr_o, ram_src[9:0]};  // A11/A10 from the DUT
    assign bus_data_i = (!ram_ce_no && !ram_oe_no) ? mem[ram_idx] : cpu_wdata;

    always @(negedge clk_16_i) begin
        if (!ram_ce_no && !ram_we_no) begin
            mem[ram_idx] <= bus_data_oe_o ? bus_data_o : cpu_wdata;
        end
    end

    // Pi slot seen from the bus side, against the frame in flight
    always @(negedge clk_16_i) begin
        if (bus_addr_oe_o === 1'b1) begin
            slot_cycles++;
            check("Pi slot address", bus_addr_o, exp_pi_addr);
            check("Pi slot rw_n", {bus_rw_n_oe_o, bus_rw_n_o}, {1'b1, exp_pi_rw_n});
            check("Pi slot CPU clock", clk_cpu_o, 1'b0);
            check("Pi slot RAM strobes", {ram_oe_no, ram_we_no}, {!exp_pi_rw_n, exp_pi_rw_n});
            check("Pi slot data enable", bus_data_oe_o, !exp_pi_rw_n);
            if (!exp_pi_rw_n) begin
                check("Pi slot write data", bus_data_o, exp_pi_wdata);
            end
        end
    end

    initial begin
        clk_16_i = 1'b0;
        forever #5 clk_16_i = ~clk_16_i;
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAIL");
        $fatal(1, "Run stopped by watchdog");
    end

    task automatic step();
        @(posedge clk_16_i);
        #1;                                                 // Drive just after the edge
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // One 4 byte mode 0 frame, returns the first byte shifted out
    task automatic spi_cmd(input logic rw_n, input pet_bus_pkg::addr_t addr,
                           input pet_bus_pkg::data_t data, output pet_bus_pkg::data_t first_rx);
        logic [31:0] frame;
        int unsigned slots_before;
        frame        = {rw_n, addr[16], 6'b0, addr[15:0], data};
        exp_pi_addr  = addr;
        exp_pi_rw_n  = rw_n;
        exp_pi_wdata = data;
        slots_before = slot_cycles;
        spi_cs_ni = 1'b0;
        repeat (4) step();                                  // Read byte loads on CS fall
        for (int i = 31; i >= 0; i--) begin
            spi_rx_i = frame[i];
            repeat (4) step();                              // MISO settles after sync
            if (i >= 24) begin
                first_rx[i-24] = spi_tx_o;
            end
            spi_sclk_i = 1'b1;
            repeat (2) step();
            spi_sclk_i = 1'b0;
        end
        repeat (4) step();
        spi_cs_ni = 1'b1;
        repeat (4) step();
        while (spi_ready_no !== 1'b0) begin
            step();                                         // Done marks the bus access
        end
        check("Pi slot length", slot_cycles - slots_before, 32'd2);  // Phases 2 and 3
    endtask

    initial begin
        void'($urandom(80));
        rst_i      = 1'b1;
        bus_addr_i = '0;
        bus_rw_n_i = 1'b1;
        cpu_wdata  = '0;
        spi_sclk_i = 1'b0;
        spi_cs_ni  = 1'b1;
        spi_rx_i   = 1'b0;
        gfx_i      = 1'b0;
        for (int a = 0; a < 8192; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;            // Every address bit counts
        end
        repeat (2) step();
        rst_i = 1'b0;

        check("strobes after reset", {ram_oe_no, ram_we_no, ram_ce_no, pia1_cs2_no,
              pia2_cs2_no, via_cs2_no, io_oe_no}, 7'h7F);
        check("cpu_res_no after reset", cpu_res_no, 1'b0);
        check("cpu_ready_o after reset", cpu_ready_o, 1'b0);

        pi_addr = 17'($urandom() % 8192);
        wdata   = 8'($urandom());
        spi_cmd(1'b0, pi_addr, wdata, rx);
        spi_cmd(1'b1, pi_addr, 8'h00, rx);
        spi_cmd(1'b1, pi_addr, 8'h00, rx);                  // Shifts out the previous read
        check("Pi read back of RAM byte", rx, wdata);

        spi_cmd(1'b0, pet_bus_pkg::ADDR_CTL, 8'h03, rx);
        check("cpu_res_no after release", cpu_res_no, 1'b1);
        check("cpu_ready_o after release", cpu_ready_o, 1'b1);

        for (int i = 0; i < N_VECS; i++) begin
            bus_addr_i = vecs[i].addr;
            bus_rw_n_i = vecs[i].rw_n;
            cpu_wdata  = 8'($urandom());
            step();
            while (clk_cpu_o !== 1'b1) begin
                step();
            end
            check($sformatf("vector %0d selects", i),
                  {pia1_cs2_no, pia2_cs2_no, via_cs2_no, io_oe_no, ram_ce_no, ram_oe_no,
                   ram_we_no, ram_addr_o},
                  {vecs[i].cs_n, vecs[i].ce_n, vecs[i].oe_n, vecs[i].we_n, vecs[i].ram_a});
            check($sformatf("vector %0d bus drive", i),
                  {bus_addr_oe_o, bus_rw_n_oe_o, bus_data_oe_o}, 3'b000);  // CPU owns the bus
        end
        bus_addr_i = '0;
        bus_rw_n_i = 1'b1;

        for (int r = 0; r < 2; r++) begin
            rows[r] = 8'($urandom());
            spi_cmd(1'b0, pet_bus_pkg::ADDR_KBD_ROWS + 17'(3 + 4 * r), rows[r], rx);
        end
        for (int r = 0; r < 2; r++) begin
            bus_addr_i = pet_bus_pkg::ADDR_PIA1;            // Port A picks the row
            bus_rw_n_i = 1'b0;
            cpu_wdata  = 8'(3 + 4 * r);
            step();
            while (cpu_en_o !== 1'b1) begin
                step();
            end
            step();
            bus_addr_i = pet_bus_pkg::ADDR_PIA1 + 17'd2;    // Port B read
            bus_rw_n_i = 1'b1;
            step();
            while (cpu_en_o !== 1'b1) begin
                step();
            end
            check("keyboard row data", bus_data_o, rows[r]);
            check("keyboard data enable", bus_data_oe_o, 1'b1);
            check("PIA1 select during key read", pia1_cs2_no, 1'b1);
            check("I/O buffer during key read", io_oe_no, 1'b1);
        end
        bus_addr_i = '0;

        spi_cmd(1'b0, pet_bus_pkg::ADDR_CTL, 8'h00, rx);
        check("cpu_res_no after hold", cpu_res_no, 1'b0);
        check("cpu_ready_o after hold", cpu_ready_o, 1'b0);
        repeat (32) begin
            step();
            check("cpu_en_o while halted", cpu_en_o, 1'b0);
        end

        gfx_i = 1'b1;
        spi_cmd(1'b1, pet_bus_pkg::ADDR_GFX, 8'h00, rx);
        gfx_i = 1'b0;
        spi_cmd(1'b1, pet_bus_pkg::ADDR_GFX, 8'h00, rx);
        check("gfx read with gfx_i high", rx, 8'h01);
        spi_cmd(1'b1, pet_bus_pkg::ADDR_GFX, 8'h00, rx);
        check("gfx read with gfx_i low", rx, 8'h00);

        if (i_main.u_main_assert.fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Bus assertions failed %0d times", i_main.u_main_assert.fail_cnt);
            $display("TEST FAIL");
            $fatal(1, "Assertion failures seen");
        end
    end

endmodule

`default_nettype wire

//--- main.f
rtl/pet_bus_pkg.sv
rtl/pet_spi_pkg.sv
rtl/spi_bridge.sv
rtl/bus_timing.sv
rtl/address_decoding.sv
rtl/keyboard.sv
rtl/pi_ctl.sv
rtl/main.sv
tb/main_assert.sv
tb/main_tb.sv
